// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/fetch_stage.sv
      - hw/imem_apb_master.sv
      - hw/fetch_unit.sv
  - target: test
    files:
      - verif/fetch_unit_assertions.sv
      - verif/fetch_unit_tb.sv

// ==== fetch_unit.f ====
hw/fetch_pkg.sv
hw/fetch_stage.sv
hw/imem_apb_master.sv
hw/fetch_unit.sv
verif/fetch_unit_assertions.sv
verif/fetch_unit_tb.sv

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

	// widths
	localparam int ADDR_W = 64;
	localparam int INSTR_W = 32;
	localparam int DATA_W = 64;

	// byte offset bits inside one bus doubleword
	localparam int BYTE_OFFS_W = 3;

	// sequential step, no compressed instructions
	localparam logic [ADDR_W-1:0] INSTR_BYTES = 64'd4;

	localparam logic [ADDR_W-1:0] RESET_PC = 64'h8000_0000;

	// apb master state encoding
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_SETUP = 2'd1;
	localparam logic [1:0] ST_ACCESS = 2'd2;

	typedef struct packed {
		logic [INSTR_W-1:0] hi;
		logic [INSTR_W-1:0] lo;
	} fetch_slots_t;

	// read data seen as a doubleword by the bus side, as two slots by fetch
	typedef union packed {
		logic [DATA_W-1:0] dword;
		fetch_slots_t slot;
	} fetch_word_u;

	typedef struct packed {
		logic jal_valid;
		logic [ADDR_W-1:0] jal_target;
		logic jalr_valid;
		logic [ADDR_W-1:0] jalr_target;
		logic br_valid;
		logic [ADDR_W-1:0] br_target;
	} redirect_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		fetch_word_u data;
		logic fault;
	} fetch_rsp_t;

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic [ADDR_W-1:0] snpc;
		logic [INSTR_W-1:0] instr;
		logic fault;
	} fetch_pkt_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic [ADDR_W-1:0] paddr;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

endpackage

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
	input  logic clk,
	input  logic reset,
	input  fetch_pkg::redirect_t redirect,
	output fetch_pkg::fetch_req_t req,
	output logic req_valid,
	input  logic req_ready,
	input  fetch_pkg::fetch_rsp_t rsp,
	input  logic rsp_valid,
	output logic rsp_ready,
	output fetch_pkg::fetch_pkt_t pkt,
	output logic pkt_valid,
	input  logic pkt_ready
);
	import fetch_pkg::*;

	logic [ADDR_W-1:0] pc_q;
	logic [ADDR_W-1:0] pc_d;
	logic outstanding_q;
	logic stale_q;
	fetch_pkt_t pkt_q;
	logic pkt_valid_q;

	logic redir_any;
	logic [ADDR_W-1:0] redir_target;
	logic req_fire;
	logic rsp_fire;
	logic rsp_take;
	logic [INSTR_W-1:0] instr_sel;
	logic [ADDR_W-1:0] rsp_snpc;

	// redirect priority, the oldest stage wins
	always_comb begin
		redir_any = 1'b1;
		redir_target = pc_q;
		if (redirect.br_valid) begin
			redir_target = redirect.br_target;
		end else if (redirect.jalr_valid) begin
			redir_target = redirect.jalr_target;
		end else if (redirect.jal_valid) begin
			redir_target = redirect.jal_target;
		end else begin
			redir_any = 1'b0;
		end
	end

	// one request at a time, a stale one also blocks
	assign req.addr = pc_q;
	assign req_valid = !outstanding_q;
	assign req_fire = req_valid && req_ready;

	// stale data is always drained
	assign rsp_ready = stale_q || !pkt_valid_q || pkt_ready;
	assign rsp_fire = rsp_valid && rsp_ready;

	// only a current response reaches decode
	assign rsp_take = rsp_fire && !stale_q && !redir_any;

	assign rsp_snpc = rsp.addr + INSTR_BYTES;

	// slot pick by address bit 2
	always_comb begin
		if (rsp.fault) begin
			instr_sel = '0;
		end else if (rsp.addr[2]) begin
			instr_sel = rsp.data.slot.hi;
		end else begin
			instr_sel = rsp.data.slot.lo;
		end
	end

	// next fetch pc
	always_comb begin
		if (redir_any) begin
			pc_d = redir_target;
		end else if (rsp_take) begin
			pc_d = rsp_snpc;
		end else begin
			pc_d = pc_q;
		end
	end

	// pc register, which also holds a latched redirect target
	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	// request accepted by the master and not yet answered
	always_ff @(posedge clk) begin
		if (reset) begin
			outstanding_q <= 1'b0;
		end else if (req_fire) begin
			outstanding_q <= 1'b1;
		end else if (rsp_fire) begin
			outstanding_q <= 1'b0;
		end
	end

	// squash of a fetch that was in flight when a redirect came
	always_ff @(posedge clk) begin
		if (reset) begin
			stale_q <= 1'b0;
		end else if (redir_any && (req_fire || (outstanding_q && !rsp_fire))) begin
			stale_q <= 1'b1;
		end else if (rsp_fire) begin
			stale_q <= 1'b0;
		end
	end

	// output register towards decode
	always_ff @(posedge clk) begin
		if (reset) begin
			pkt_valid_q <= 1'b0;
		end else if (redir_any) begin
			// old stream packet is dropped
			pkt_valid_q <= 1'b0;
		end else if (rsp_take) begin
			pkt_valid_q <= 1'b1;
		end else if (pkt_ready) begin
			pkt_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_take) begin
			pkt_q.pc <= rsp.addr;
			pkt_q.snpc <= rsp_snpc;
			pkt_q.instr <= instr_sel;
			pkt_q.fault <= rsp.fault;
		end
	end

	assign pkt = pkt_q;
	assign pkt_valid = pkt_valid_q;

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
	input  logic clk,
	input  logic reset,
	input  fetch_pkg::redirect_t redirect,
	output fetch_pkg::fetch_pkt_t pkt,
	output logic pkt_valid,
	input  logic pkt_ready,
	output fetch_pkg::apb_req_t apb_req,
	input  fetch_pkg::apb_rsp_t apb_rsp
);
	import fetch_pkg::*;

	// fetch stage to bus master
	fetch_req_t req;
	logic req_valid;
	logic req_ready;
	fetch_rsp_t rsp;
	logic rsp_valid;
	logic rsp_ready;

	fetch_stage fetch_stage_i (
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.pkt(pkt),
		.pkt_valid(pkt_valid),
		.pkt_ready(pkt_ready)
	);

	imem_apb_master imem_apb_master_i (
		.clk(clk),
		.reset(reset),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

endmodule

// ==== hw/imem_apb_master.sv ====
`timescale 1ns/1ps

module imem_apb_master (
	input  logic clk,
	input  logic reset,
	input  fetch_pkg::fetch_req_t req,
	input  logic req_valid,
	output logic req_ready,
	output fetch_pkg::fetch_rsp_t rsp,
	output logic rsp_valid,
	input  logic rsp_ready,
	output fetch_pkg::apb_req_t apb_req,
	input  fetch_pkg::apb_rsp_t apb_rsp
);
	import fetch_pkg::*;

	logic [1:0] state_q;
	logic [1:0] state_d;
	logic [ADDR_W-1:0] addr_q;
	fetch_rsp_t rsp_q;
	logic rsp_valid_q;
	logic req_fire;
	logic done;

	// idle and nothing waiting for the fetch stage
	assign req_ready = (state_q == ST_IDLE) && !rsp_valid_q;
	assign req_fire = req_valid && req_ready;

	// access phase ends with pready
	assign done = (state_q == ST_ACCESS) && apb_rsp.pready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (req_fire) begin
					state_d = ST_SETUP;
				end
			end
			ST_SETUP: begin
				state_d = ST_ACCESS;
			end
			ST_ACCESS: begin
				if (apb_rsp.pready) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// request address, kept from setup until the response is built
	always_ff @(posedge clk) begin
		if (req_fire) begin
			addr_q <= req.addr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid_q <= 1'b0;
		end else if (done) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_valid_q && rsp_ready) begin
			rsp_valid_q <= 1'b0;
		end
	end

	// original address goes back so fetch can pick the slot
	always_ff @(posedge clk) begin
		if (done) begin
			rsp_q.addr <= addr_q;
			rsp_q.data.dword <= apb_rsp.prdata;
			rsp_q.fault <= apb_rsp.pslverr;
		end
	end

	assign apb_req.psel = (state_q != ST_IDLE);
	assign apb_req.penable = (state_q == ST_ACCESS);
	// doubleword aligned bus address
	assign apb_req.paddr = {addr_q[ADDR_W-1:BYTE_OFFS_W], {BYTE_OFFS_W{1'b0}}};

	assign rsp = rsp_q;
	assign rsp_valid = rsp_valid_q;

endmodule

// ==== verif/fetch_unit_assertions.sv ====
`timescale 1ns/1ps

module fetch_unit_assertions (
	input logic clk,
	input logic reset,
	input fetch_pkg::fetch_pkt_t pkt,
	input logic pkt_valid,
	input logic pkt_ready,
	input fetch_pkg::apb_req_t apb_req,
	input fetch_pkg::apb_rsp_t apb_rsp,
	input logic rsp_valid,
	input logic rsp_ready
);
	int fail_count = 0;

	// access phase comes right after setup
	assert property (@(posedge clk) disable iff (reset)
		apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
		else begin
			$error("apb access phase did not follow the setup cycle");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (reset)
		$rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
		else begin
			$error("penable rose without a setup cycle before it");
			fail_count++;
		end

	// address held from setup until pready ends the transfer
	assert property (@(posedge clk) disable iff (reset)
		apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=> $stable(apb_req.paddr))
		else begin
			$error("paddr changed during an apb transfer");
			fail_count++;
		end

	// packet may only be dropped by a redirect, never changed
	assert property (@(posedge clk) disable iff (reset)
		pkt_valid && !pkt_ready |=> !pkt_valid || $stable(pkt))
		else begin
			$error("decode packet changed while waiting for ready");
			fail_count++;
		end

	// response stuck behind decode, bus stays quiet
	assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !rsp_ready |-> !apb_req.psel)
		else begin
			$error("apb read started while a response was waiting");
			fail_count++;
		end

endmodule

// ==== verif/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb;
	import fetch_pkg::*;

	localparam logic [31:0] SEED = 32'h548a25ed;
	localparam int MEM_WORDS = 64;
	localparam logic [ADDR_W-1:0] MEM_BASE = RESET_PC;
	localparam logic [ADDR_W-1:0] MEM_BYTES = MEM_WORDS * 8;
	// packets the tests wait for, and worst case cycles per fetch
	localparam int TOTAL_INSTR = 78;
	localparam int MAX_FETCH_LAT = 8;
	localparam int CYCLE_LIMIT = 4 * TOTAL_INSTR * MAX_FETCH_LAT + 200;

	logic clk;
	logic reset;
	redirect_t redirect;
	fetch_pkt_t pkt;
	logic pkt_valid;
	logic pkt_ready;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [31:0] rng_bus;
	logic [31:0] rng_rdy;
	logic ready_random;
	int wait_cnt;
	logic [ADDR_W-1:0] exp_pc;
	logic [ADDR_W-1:0] first_pc;
	logic [ADDR_W-1:0] last_pc;
	logic held_valid;
	fetch_pkt_t held_pkt;
	int pkt_count;
	int stall_cycles;
	int fault_count;
	int errors;
	int checks;
	int cycle_count;

	fetch_unit fetch_unit_i (
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.pkt(pkt),
		.pkt_valid(pkt_valid),
		.pkt_ready(pkt_ready),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	bind fetch_unit fetch_unit_assertions fetch_unit_assertions_i (
		.clk(clk),
		.reset(reset),
		.pkt(pkt),
		.pkt_valid(pkt_valid),
		.pkt_ready(pkt_ready),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic in_mem(input logic [ADDR_W-1:0] addr);
		return (addr >= MEM_BASE) && (addr < MEM_BASE + MEM_BYTES);
	endfunction

	function automatic int mem_index(input logic [ADDR_W-1:0] addr);
		return int'((addr - MEM_BASE) >> 3);
	endfunction

	// lo half for pc bit 2 clear, hi half otherwise, zero when unmapped
	function automatic logic [INSTR_W-1:0] expected_instr(input logic [ADDR_W-1:0] pc);
		logic [DATA_W-1:0] word;
		if (!in_mem(pc)) begin
			return '0;
		end
		word = mem[mem_index(pc)];
		return pc[2] ? word[63:32] : word[31:0];
	endfunction

	// oldest stage wins
	function automatic logic [ADDR_W-1:0] chosen_target(input redirect_t r);
		if (r.br_valid) begin
			return r.br_target;
		end else if (r.jalr_valid) begin
			return r.jalr_target;
		end
		return r.jal_target;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expv);
		checks = checks + 1;
		assert (got === expv) else begin
			errors = errors + 1;
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, expv);
		end
	endtask

	// apb slave, 0 to 3 wait states per access
	always @(posedge clk) begin
		if (reset) begin
			apb_rsp <= '0;
			wait_cnt <= 0;
		end else if (apb_req.psel && !apb_req.penable) begin
			rng_bus = xorshift(rng_bus);
			wait_cnt <= rng_bus[1:0];
			apb_rsp.pready <= (rng_bus[1:0] == 2'd0);
			apb_rsp.pslverr <= !in_mem(apb_req.paddr);
			apb_rsp.prdata <= in_mem(apb_req.paddr) ? mem[mem_index(apb_req.paddr)] : '0;
		end else if (apb_req.psel && apb_req.penable && !apb_rsp.pready) begin
			wait_cnt <= wait_cnt - 1;
			apb_rsp.pready <= (wait_cnt == 1);
		end else begin
			apb_rsp.pready <= 1'b0;
		end
	end

	// decode side ready
	always @(posedge clk) begin
		if (ready_random) begin
			rng_rdy = xorshift(rng_rdy);
			pkt_ready <= rng_rdy[0];
		end else begin
			pkt_ready <= 1'b1;
		end
	end

	// reference pc model, sampled mid cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (held_valid && pkt_valid) begin
				checks = checks + 1;
				assert (pkt === held_pkt) else begin
					errors = errors + 1;
					$display("** Error at %0t: pkt got %h expected %h", $time, pkt, held_pkt);
				end
			end
			if (pkt_valid && pkt_ready) begin
				check_value("pkt.pc", pkt.pc, exp_pc);
				check_value("pkt.snpc", pkt.snpc, exp_pc + 64'd4);
				check_value("pkt.instr", pkt.instr, expected_instr(exp_pc));
				check_value("pkt.fault", pkt.fault, !in_mem(exp_pc));
				if (pkt_count == 0) begin
					first_pc = pkt.pc;
				end
				if (pkt.fault) begin
					fault_count = fault_count + 1;
				end
				last_pc = pkt.pc;
				pkt_count = pkt_count + 1;
				exp_pc = exp_pc + 64'd4;
			end
			if (pkt_valid && !pkt_ready) begin
				stall_cycles = stall_cycles + 1;
			end
			if (redirect.br_valid || redirect.jalr_valid || redirect.jal_valid) begin
				exp_pc = chosen_target(redirect);
			end
			held_valid = pkt_valid && !pkt_ready;
			held_pkt = pkt;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d packets taken", cycle_count, pkt_count);
			$display("errors: %0d, checks: %0d", errors, checks);
			$display("test failed");
			$finish;
		end
	end

	task automatic wait_packets(input int n);
		int target;
		target = pkt_count + n;
		while (pkt_count < target) begin
			@(posedge clk);
		end
	endtask

	// redirect for one cycle while a read is on the bus
	task automatic redirect_test(input redirect_t r, input logic [ADDR_W-1:0] target,
			input int count);
		@(posedge clk);
		while (!apb_req.psel) begin
			@(posedge clk);
		end
		redirect <= r;
		@(posedge clk);
		redirect <= '0;
		wait_packets(1);
		check_value("pc after redirect", last_pc, target);
		wait_packets(count - 1);
	endtask

	task automatic reset_sequence_test();
		check_value("pkt_valid in reset", pkt_valid, 1'b0);
		check_value("apb psel in reset", apb_req.psel, 1'b0);
		wait_packets(16);
		check_value("first pc", first_pc, RESET_PC);
	endtask

	task automatic backpressure_test();
		ready_random <= 1'b1;
		wait_packets(24);
		ready_random <= 1'b0;
		assert (stall_cycles > 0) else begin
			errors = errors + 1;
			$display("decode never stalled during the back-pressure test");
		end
	endtask

	task automatic redirect_kind_test();
		redirect_t r;
		r = '0;
		r.jal_valid = 1'b1;
		r.jal_target = MEM_BASE + 64'h40;
		redirect_test(r, MEM_BASE + 64'h40, 6);
		r = '0;
		r.jalr_valid = 1'b1;
		r.jalr_target = MEM_BASE + 64'h84;
		redirect_test(r, MEM_BASE + 64'h84, 6);
		r = '0;
		r.br_valid = 1'b1;
		r.br_target = MEM_BASE + 64'h100;
		redirect_test(r, MEM_BASE + 64'h100, 6);
	endtask

	task automatic priority_test();
		redirect_t r;
		r = '0;
		r.jal_valid = 1'b1;
		r.jal_target = MEM_BASE + 64'h20;
		r.jalr_valid = 1'b1;
		r.jalr_target = MEM_BASE + 64'h60;
		r.br_valid = 1'b1;
		r.br_target = MEM_BASE + 64'h180;
		redirect_test(r, MEM_BASE + 64'h180, 6);
		r.br_valid = 1'b0;
		r.jal_target = MEM_BASE + 64'h10;
		r.jalr_target = MEM_BASE + 64'h1c0;
		redirect_test(r, MEM_BASE + 64'h1c0, 6);
	endtask

	// last mapped word, then two unmapped slots
	task automatic fault_test();
		redirect_t r;
		r = '0;
		r.jal_valid = 1'b1;
		r.jal_target = MEM_BASE + MEM_BYTES - 64'd8;
		redirect_test(r, MEM_BASE + MEM_BYTES - 64'd8, 4);
		check_value("pc after fault", last_pc, MEM_BASE + MEM_BYTES + 64'd4);
		assert (fault_count >= 2) else begin
			errors = errors + 1;
			$display("no faulting packet came back from the unmapped address");
		end
		r.jal_target = MEM_BASE + 64'd4;
		redirect_test(r, MEM_BASE + 64'd4, 4);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		redirect = '0;
		pkt_ready = 1'b0;
		apb_rsp = '0;
		ready_random = 1'b0;
		exp_pc = RESET_PC;
		first_pc = '0;
		last_pc = '0;
		held_valid = 1'b0;
		held_pkt = '0;
		pkt_count = 0;
		stall_cycles = 0;
		fault_count = 0;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		rng_bus = SEED;
		for (int i = 0; i < MEM_WORDS; i++) begin
			rng_bus = xorshift(rng_bus);
			mem[i][31:0] = rng_bus;
			rng_bus = xorshift(rng_bus);
			mem[i][63:32] = rng_bus;
		end
		rng_rdy = xorshift(rng_bus);
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		reset_sequence_test();
		backpressure_test();
		redirect_kind_test();
		priority_test();
		fault_test();
		repeat (4) @(posedge clk);
		// bound protocol checks count as errors too
		errors = errors + fetch_unit_i.fetch_unit_assertions_i.fail_count;
		$display("errors: %0d, checks: %0d, packets: %0d", errors, checks, pkt_count);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
